// File: verilog/sparse_buffer_pkg.sv
/*
 * sparse sample buffer shared types
 * sample, word, timestamp and FIFO entry vectors plus the
 * readout formatter state encoding
 */

`default_nettype none

package sparse_buffer_pkg;

  //////////////////////////////////////////////////
  // sample and word geometry
  //////////////////////////////////////////////////
  localparam int SAMPLE_WIDTH = 16;
  localparam int PARALLEL_SAMPLES = 4;
  localparam int WORD_WIDTH = SAMPLE_WIDTH * PARALLEL_SAMPLES;
  localparam int TIMESTAMP_WIDTH = 32;

  typedef logic [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [TIMESTAMP_WIDTH-1:0] timestamp_t;

  //////////////////////////////////////////////////
  // FIFO entry layout
  //////////////////////////////////////////////////
  // msb first: segment start, timestamp, data word
  localparam int ENTRY_WIDTH = 1 + TIMESTAMP_WIDTH + WORD_WIDTH;
  localparam int ENTRY_STAMP_LSB = WORD_WIDTH;
  localparam int ENTRY_START_BIT = WORD_WIDTH + TIMESTAMP_WIDTH;

  typedef logic [ENTRY_WIDTH-1:0] entry_t;

  // readout formatter states
  typedef enum logic [1:0] {
    fmt_idle,
    fmt_stamp,
    fmt_data
  } fmt_state_t;

endpackage

`default_nettype wire

// File: verilog/sample_discriminator.sv
/*
 * sample discriminator
 * tracks capture state and the word index, and applies a hysteresis
 * rule to pick the words that go into the FIFO
 */

`timescale 1ns/1ps
`default_nettype none

module sample_discriminator
  import sparse_buffer_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,

  input  wire logic    capture_start,
  input  wire logic    capture_stop,
  input  wire sample_t threshold_high,
  input  wire sample_t threshold_low,

  input  wire logic  in_valid,
  input  wire word_t in_data,

  output logic   wr_valid,
  output entry_t wr_entry,
  output logic   capturing
);

  // index of the next word seen while capturing
  timestamp_t word_index;
  // set while inside a kept segment
  logic active;

  logic any_high;
  logic all_low;
  logic keep;
  logic seg_start;

  //////////////////////////////////////////////////
  // threshold comparison over all parallel samples
  //////////////////////////////////////////////////
  always_comb begin
    any_high = 1'b0;
    all_low = 1'b1;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      if (sample_t'(in_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]) > threshold_high) begin
        any_high = 1'b1;
      end
      if (sample_t'(in_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]) >= threshold_low) begin
        all_low = 1'b0;
      end
    end
  end

  // outside a segment a high word opens one, inside it everything
  // but an all-low word continues it
  assign seg_start = ~active;
  assign keep = active ? ~all_low : any_high;

  //////////////////////////////////////////////////
  // capture control and hysteresis state
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      capturing <= 1'b0;
      word_index <= '0;
      active <= 1'b0;
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= 1'b0;
      if (capture_start) begin
        // start wins over a word arriving in the same cycle
        capturing <= 1'b1;
        word_index <= '0;
        active <= 1'b0;
      end else begin
        if (capture_stop) begin
          capturing <= 1'b0;
        end
        if (capturing && in_valid) begin
          word_index <= word_index + 1'b1;
          wr_valid <= keep;
          if (!active && any_high) begin
            active <= 1'b1;
          end else if (active && all_low) begin
            active <= 1'b0;
          end
        end
      end
    end
  end

  // entry payload, qualified by wr_valid
  always_ff @(posedge clk) begin
    if (capturing && in_valid) begin
      wr_entry <= {seg_start, word_index, in_data};
    end
  end

endmodule

`default_nettype wire

// File: verilog/sample_fifo.sv
/*
 * sample FIFO
 * circular buffer of tagged entries with an occupancy count; writes
 * into a full FIFO are dropped and latch a sticky overflow flag
 */

`timescale 1ns/1ps
`default_nettype none

module sample_fifo
  import sparse_buffer_pkg::*;
#(
  parameter int DEPTH = 32
) (
  input  wire logic clk,
  input  wire logic reset,

  input  wire logic capture_start,

  input  wire logic   wr_valid,
  input  wire entry_t wr_entry,

  output logic   rd_valid,
  output entry_t rd_entry,
  input  wire logic rd_ready,

  output logic overflow
);

  localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [COUNT_WIDTH-1:0] count_t;

  entry_t mem [DEPTH];

  addr_t  wr_ptr;
  addr_t  rd_ptr;
  count_t count;

  logic full;
  logic do_write;
  logic do_read;

  assign full = (count == count_t'(DEPTH));
  assign rd_valid = (count != '0);
  assign rd_entry = mem[rd_ptr];

  assign do_write = wr_valid && !full;
  assign do_read = rd_valid && rd_ready;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  //////////////////////////////////////////////////
  // pointers and occupancy
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_write) begin
        // DEPTH need not be a power of two
        wr_ptr <= (wr_ptr == addr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == addr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // sticky overflow, a drop in the start cycle still counts
  always_ff @(posedge clk) begin
    if (reset) begin
      overflow <= 1'b0;
    end else begin
      if (capture_start) begin
        overflow <= 1'b0;
      end
      if (wr_valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/readout_formatter.sv
/*
 * readout formatter
 * pops FIFO entries and presents them as a valid/ready stream, putting
 * a timestamp word in front of the first data word of every segment
 */

`timescale 1ns/1ps
`default_nettype none

module readout_formatter
  import sparse_buffer_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,

  input  wire logic   rd_valid,
  input  wire entry_t rd_entry,
  output logic        rd_ready,

  output logic  out_valid,
  output word_t out_data,
  output logic  out_is_stamp,
  input  wire logic out_ready
);

  fmt_state_t state;
  entry_t     hold_entry;

  logic       take;
  fmt_state_t load_state;
  timestamp_t hold_stamp;

  //////////////////////////////////////////////////
  // pop control
  //////////////////////////////////////////////////
  // empty holding register, or its last word leaves this cycle
  assign rd_ready = (state == fmt_idle) || ((state == fmt_data) && out_ready);
  assign take = rd_valid && rd_ready;

  // segment starts get their timestamp word first
  assign load_state = rd_entry[ENTRY_START_BIT] ? fmt_stamp : fmt_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fmt_idle;
    end else begin
      case (state)
        fmt_idle: begin
          if (take) begin
            state <= load_state;
          end
        end
        fmt_stamp: begin
          if (out_ready) begin
            state <= fmt_data;
          end
        end
        fmt_data: begin
          if (out_ready) begin
            state <= take ? load_state : fmt_idle;
          end
        end
        default: state <= fmt_idle;
      endcase
    end
  end

  // holding register
  always_ff @(posedge clk) begin
    if (take) begin
      hold_entry <= rd_entry;
    end
  end

  //////////////////////////////////////////////////
  // output stream
  //////////////////////////////////////////////////
  // everything below comes from registers, so it holds while stalled
  assign hold_stamp = hold_entry[ENTRY_STAMP_LSB +: TIMESTAMP_WIDTH];

  assign out_valid = (state != fmt_idle);
  assign out_is_stamp = (state == fmt_stamp);

  always_comb begin
    if (state == fmt_stamp) begin
      out_data = {{(WORD_WIDTH - TIMESTAMP_WIDTH){1'b0}}, hold_stamp};
    end else begin
      out_data = hold_entry[WORD_WIDTH-1:0];
    end
  end

endmodule

`default_nettype wire

// File: verilog/sparse_sample_buffer.sv
/*
 * sparse sample buffer
 * discriminator, FIFO and readout formatter for one channel
 */

`timescale 1ns/1ps
`default_nettype none

module sparse_sample_buffer
  import sparse_buffer_pkg::*;
#(
  parameter int DEPTH = 32
) (
  input  wire logic clk,
  input  wire logic reset,

  // capture control and thresholds, held while idle
  input  wire logic    capture_start,
  input  wire logic    capture_stop,
  input  wire sample_t threshold_high,
  input  wire sample_t threshold_low,

  // sample stream, never stalled
  input  wire logic  in_valid,
  input  wire word_t in_data,

  // readout stream
  output logic  out_valid,
  output word_t out_data,
  output logic  out_is_stamp,
  input  wire logic out_ready,

  // status
  output logic capturing,
  output logic overflow
);

  //////////////////////////////////////////////////
  // internal streams
  //////////////////////////////////////////////////
  logic   wr_valid;
  entry_t wr_entry;

  logic   rd_valid;
  entry_t rd_entry;
  logic   rd_ready;

  sample_discriminator discriminator_i (
    .clk            (clk),
    .reset          (reset),
    .capture_start  (capture_start),
    .capture_stop   (capture_stop),
    .threshold_high (threshold_high),
    .threshold_low  (threshold_low),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .wr_valid       (wr_valid),
    .wr_entry       (wr_entry),
    .capturing      (capturing)
  );

  sample_fifo #(
    .DEPTH (DEPTH)
  ) fifo_i (
    .clk           (clk),
    .reset         (reset),
    .capture_start (capture_start),
    .wr_valid      (wr_valid),
    .wr_entry      (wr_entry),
    .rd_valid      (rd_valid),
    .rd_entry      (rd_entry),
    .rd_ready      (rd_ready),
    .overflow      (overflow)
  );

  readout_formatter formatter_i (
    .clk          (clk),
    .reset        (reset),
    .rd_valid     (rd_valid),
    .rd_entry     (rd_entry),
    .rd_ready     (rd_ready),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_is_stamp (out_is_stamp),
    .out_ready    (out_ready)
  );

endmodule

`default_nettype wire

// File: test/sparse_sample_buffer_checker.sv
/*
 * sparse sample buffer checker
 * concurrent assertions on the readout stream, reset state and the
 * sticky FIFO overflow flag
 */

`timescale 1ns/1ps
`default_nettype none

module sparse_sample_buffer_checker
  import sparse_buffer_pkg::*;
(
  input wire logic  clk,
  input wire logic  reset,
  input wire logic  capture_start,
  input wire logic  wr_valid,
  input wire logic  rd_valid,
  input wire logic  out_valid,
  input wire word_t out_data,
  input wire logic  out_is_stamp,
  input wire logic  out_ready,
  input wire logic  capturing,
  input wire logic  overflow
);

  // number of failed assertions
  int error_count = 0;

  //////////////////////////////////////////////////
  // readout stream
  //////////////////////////////////////////////////
  // a stalled word holds until it is accepted
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_is_stamp))
    else begin
      $error("output stream changed while stalled");
      error_count++;
    end

  //////////////////////////////////////////////////
  // reset and status flags
  //////////////////////////////////////////////////
  assert property (@(posedge clk)
    reset |=> !wr_valid && !rd_valid && !out_valid && !capturing && !overflow)
    else begin
      $error("valid or status flag high in the cycle after reset");
      error_count++;
    end

  // overflow is only cleared by a new capture or by reset
  assert property (@(posedge clk) disable iff (reset)
    $fell(overflow) |-> $past(capture_start) || $past(reset))
    else begin
      $error("overflow fell without capture_start");
      error_count++;
    end

endmodule

bind sparse_sample_buffer sparse_sample_buffer_checker checker_i (
  .clk           (clk),
  .reset         (reset),
  .capture_start (capture_start),
  .wr_valid      (wr_valid),
  .rd_valid      (rd_valid),
  .out_valid     (out_valid),
  .out_data      (out_data),
  .out_is_stamp  (out_is_stamp),
  .out_ready     (out_ready),
  .capturing     (capturing),
  .overflow      (overflow)
);

`default_nettype wire

// File: test/sparse_sample_buffer_tb.sv
/*
 * sparse sample buffer testbench
 * random sample words against a reference model of the hysteresis
 * capture and the timestamp-first readout stream
 */

`timescale 1ns/1ps
`default_nettype none

module sparse_sample_buffer_tb
  import sparse_buffer_pkg::*;
();

  localparam int DEPTH = 8;
  localparam int TIMEOUT = 2000;

  logic    clk;
  logic    reset;
  logic    capture_start;
  logic    capture_stop;
  sample_t threshold_high;
  sample_t threshold_low;
  logic    in_valid;
  word_t   in_data;
  logic    out_valid;
  word_t   out_data;
  logic    out_is_stamp;
  logic    out_ready;
  logic    capturing;
  logic    overflow;

  integer seed = 15;
  int ready_pct;
  int data_seen;

  // expected output stream, head is the next word
  word_t exp_data[$];
  logic  exp_stamp[$];

  // reference model state
  logic       m_capturing;
  logic       m_active;
  timestamp_t m_index;

  sparse_sample_buffer #(
    .DEPTH (DEPTH)
  ) UUT (
    .clk            (clk),
    .reset          (reset),
    .capture_start  (capture_start),
    .capture_stop   (capture_stop),
    .threshold_high (threshold_high),
    .threshold_low  (threshold_low),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_is_stamp   (out_is_stamp),
    .out_ready      (out_ready),
    .capturing      (capturing),
    .overflow       (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random helpers
  //////////////////////////////////////////////////
  function automatic logic rand_chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic word_t rand_word(input sample_t lo, input sample_t hi);
    word_t w;
    int unsigned span;
    span = int'(hi) - int'(lo) + 1;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      w[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lo + sample_t'($unsigned($random(seed)) % span);
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // error reporting and compare tasks
  //////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // assertion failures counted by the bound checker
  always @(UUT.checker_i.error_count) begin
    if (UUT.checker_i.error_count != 0) begin
      abort_run($sformatf("assertion failed in the bound checker at %0t ns", $time));
    end
  end

  // handshake completes at the next rising edge
  task automatic check_output();
    if (out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        abort_run($sformatf("unexpected output word %h at %0t ns", out_data, $time));
      end
      check_flag(out_is_stamp, exp_stamp.pop_front(), "out_is_stamp");
      check_word(out_data, exp_data.pop_front(), "out_data");
      if (!out_is_stamp) begin
        data_seen++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  task automatic model_input(input logic start, input logic stop, input logic vin,
                             input word_t data);
    logic    any_high;
    logic    all_low;
    sample_t s;
    if (m_capturing && vin && !start) begin
      any_high = 1'b0;
      all_low = 1'b1;
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        s = data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
        any_high |= (s > threshold_high);
        all_low &= (s < threshold_low);
      end
      if (!m_active && any_high) begin
        // new segment, timestamp word goes first
        exp_data.push_back(word_t'(m_index));
        exp_stamp.push_back(1'b1);
        exp_data.push_back(data);
        exp_stamp.push_back(1'b0);
        m_active = 1'b1;
      end else if (m_active && all_low) begin
        m_active = 1'b0;
      end else if (m_active) begin
        exp_data.push_back(data);
        exp_stamp.push_back(1'b0);
      end
      m_index++;
    end
    if (start) begin
      m_capturing = 1'b1;
      m_index = '0;
      m_active = 1'b0;
    end else if (stop) begin
      m_capturing = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  task automatic drive_cycle(input logic start, input logic stop, input logic vin,
                             input word_t data, input logic ready);
    @(negedge clk);
    capture_start = start;
    capture_stop = stop;
    in_valid = vin;
    in_data = data;
    out_ready = ready;
    check_output();
    model_input(start, stop, vin, data);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, 1'b0, 1'b0, '0, rand_chance(ready_pct));
  endtask

  task automatic feed(input int n, input sample_t lo, input sample_t hi, input int valid_pct);
    logic  vin;
    word_t w;
    for (int i = 0; i < n; i++) begin
      vin = rand_chance(valid_pct);
      w = rand_word(lo, hi);
      drive_cycle(1'b0, 1'b0, vin, w, rand_chance(ready_pct));
    end
  endtask

  task automatic start_capture();
    drive_cycle(1'b1, 1'b0, 1'b0, '0, rand_chance(ready_pct));
  endtask

  task automatic stop_capture();
    drive_cycle(1'b0, 1'b1, 1'b0, '0, rand_chance(ready_pct));
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_data.size() != 0 || out_valid) begin
      if (n == TIMEOUT) begin
        abort_run("timeout: output stream did not drain the expected words");
      end
      idle_cycle();
      n++;
    end
  endtask

  task automatic wait_overflow();
    int n;
    n = 0;
    while (!overflow) begin
      if (n == TIMEOUT) begin
        abort_run("timeout: overflow never went high with the output stalled");
      end
      idle_cycle();
      n++;
    end
  endtask

  // done once out_valid has stayed low for a few cycles
  task automatic wait_stream_idle();
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 4) begin
      if (n == TIMEOUT) begin
        abort_run("timeout: output stream kept running after the FIFO drained");
      end
      idle_cycle();
      quiet = out_valid ? 0 : quiet + 1;
      n++;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int first_seen;
    int drained;
    reset = 1'b1;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    threshold_high = '0;
    threshold_low = '0;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b0;
    m_capturing = 1'b0;
    m_active = 1'b0;
    m_index = '0;
    data_seen = 0;
    ready_pct = 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(capturing, 1'b0, "capturing after reset");
    check_flag(overflow, 1'b0, "overflow after reset");

    // every word kept, words outside the capture window ignored
    threshold_high = 16'h0100;
    threshold_low = 16'h0000;
    feed(8, 16'h03c0, 16'h04ff, 100);
    start_capture();
    feed(40, 16'h03c0, 16'h04ff, 100);
    stop_capture();
    feed(8, 16'h03c0, 16'h04ff, 100);
    wait_drained();
    check_flag(overflow, 1'b0, "overflow after full capture");

    // hysteresis band with random back-pressure, index restarts at 0
    ready_pct = 75;
    threshold_high = 16'h0400;
    threshold_low = 16'h01c0;
    start_capture();
    for (int r = 0; r < 20; r++) begin
      feed(12, 16'h00ff, 16'h04ff, 25);
      feed(6, 16'h00ff, 16'h01bf, 25);
    end
    stop_capture();
    wait_drained();
    check_flag(overflow, 1'b0, "overflow after hysteresis capture");

    // nothing crosses threshold_high
    ready_pct = 100;
    threshold_low = 16'h0100;
    start_capture();
    idle_cycle();
    check_flag(capturing, 1'b1, "capturing while running");
    feed(60, 16'h0000, 16'h03ff, 50);
    check_flag(capturing, 1'b1, "capturing while running");
    stop_capture();
    idle_cycle();
    check_flag(capturing, 1'b0, "capturing after stop");
    wait_drained();

    // stalled output, FIFO overflows
    ready_pct = 0;
    threshold_high = 16'h0100;
    threshold_low = 16'h0000;
    start_capture();
    feed(DEPTH + 6, 16'h03c0, 16'h04ff, 100);
    wait_overflow();
    stop_capture();
    first_seen = data_seen;
    ready_pct = 100;
    wait_stream_idle();
    drained = data_seen - first_seen;
    if (drained < DEPTH || drained > DEPTH + 1) begin
      abort_run($sformatf("drained %0d data words after overflow, expected %0d or %0d",
                          drained, DEPTH, DEPTH + 1));
    end
    exp_data.delete();
    exp_stamp.delete();
    check_flag(overflow, 1'b1, "overflow after drain");
    start_capture();
    idle_cycle();
    check_flag(overflow, 1'b0, "overflow after capture_start");
    stop_capture();
    wait_drained();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
verilog/sparse_buffer_pkg.sv
verilog/sample_discriminator.sv
verilog/sample_fifo.sv
verilog/readout_formatter.sv
verilog/sparse_sample_buffer.sv
test/sparse_sample_buffer_checker.sv
test/sparse_sample_buffer_tb.sv

// File: Bender.yml
package:
  name: sparse_sample_buffer

sources:
  # RTL, package first
  - target: any(rtl, test)
    files:
      - verilog/sparse_buffer_pkg.sv
      - verilog/sample_discriminator.sv
      - verilog/sample_fifo.sv
      - verilog/readout_formatter.sv
      - verilog/sparse_sample_buffer.sv
  # testbench and bound checker
  - target: test
    files:
      - test/sparse_sample_buffer_checker.sv
      - test/sparse_sample_buffer_tb.sv
